// File: list.f
+incdir+.
tracker_pkg.sv
raster_timer.sv
pixel_classifier.sv
centroid_divider.sv
centroid_tracker.sv
overlay_mux.sv
chroma_key_top.sv
tb_chroma_key.sv

// File: Bender.yml
package:
  name: chroma_key_tracker

sources:
  - files:
      - tracker_pkg.sv
      - raster_timer.sv
      - pixel_classifier.sv
      - centroid_divider.sv
      - centroid_tracker.sv
      - overlay_mux.sv
      - chroma_key_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_chroma_key.sv

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ===========================================================================
// colour model
// ===========================================================================

// 5:6:5 fields left aligned into 8 bits, low bits zero
function automatic logic [23:0] expand_565(input logic [15:0] pix);
  return {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000};
endfunction

// Y = (66R + 129G + 25B)/256 + 16, kept to 8 bits
function automatic logic [7:0] luma_of(input logic [15:0] pix);
  logic [23:0] rgb;
  int y;
  rgb = expand_565(pix);
  y = (66 * int'(rgb[23:16]) + 129 * int'(rgb[15:8]) + 25 * int'(rgb[7:0])) >>> 8;
  return 8'(y + 16);
endfunction

// backdrop when both chroma channels sit at or below key * 16
function automatic bit is_backdrop(input logic [15:0] pix, input logic [3:0] key);
  logic [23:0] rgb;
  int r, g, b;
  int cr, cb;
  rgb = expand_565(pix);
  r = int'(rgb[23:16]);
  g = int'(rgb[15:8]);
  b = int'(rgb[7:0]);
  // arithmetic shift gives the floor of a negative sum
  cr = (((112 * r - 94 * g - 18 * b) >>> 8) + 128) & 255;
  cb = (((112 * b - 38 * r - 74 * g) >>> 8) + 128) & 255;
  return (cr <= int'(key) * 16) && (cb <= int'(key) * 16);
endfunction

// ===========================================================================
// window, player and output pixel
// ===========================================================================

// one tenth of each edge is outside
function automatic bit in_window(input int x, input int y, input int w, input int h);
  return (x >= w / WINDOW_DIV) && (x < w - w / WINDOW_DIV) &&
         (y >= h / WINDOW_DIV) && (y < h - h / WINDOW_DIV);
endfunction

function automatic bit is_player(input logic [15:0] pix, input int x, input int y,
                                 input int w, input int h, input logic [3:0] key);
  return !is_backdrop(pix, key) && in_window(x, y, w, h);
endfunction

function automatic logic [23:0] expect_pixel(input logic [1:0] mode, input logic [15:0] pix,
                                             input bit player, input int x, input int y,
                                             input bit cross_on, input int cx, input int cy);
  logic [23:0] bg;
  case (mode)
    DISP_CAMERA: bg = expand_565(pix);
    DISP_LUMA:   bg = {3{luma_of(pix)}};
    DISP_MASK:   bg = player ? 24'hFFFFFF : 24'h000000;
    default:     bg = player ? MASK_COLOR : expand_565(pix);
  endcase
  // crosshair row and column through the tracked centre
  if (cross_on && ((x == cx) || (y == cy))) begin
    bg = CROSS_COLOR;
  end
  return bg;
endfunction

// floor mean of the player coordinates
function automatic int floor_mean(input longint sum, input int count);
  return int'(sum / count);
endfunction

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

`endif

// File: tb_chroma_key.sv
`timescale 1ns/10ps

module tb_chroma_key import tracker_pkg::*; ();

  // small raster with window margins of 3 pixels and 1 line
  localparam int TB_H         = 32;
  localparam int TB_V         = 18;
  localparam int CLK_PERIOD   = 4;
  localparam int FRAME_PIXELS = TB_H * TB_V;
  localparam int H_TOTAL      = TB_H + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = TB_V + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // twelve frames plus margin
  localparam int WATCHDOG_NS  = (12 * FRAME_CYCLES + 1000) * CLK_PERIOD;

  // scene kinds for one frame of stimulus
  localparam int SCENE_RANDOM = 0;
  localparam int SCENE_FILL   = 1;
  localparam int SCENE_BLOCK  = 2;
  localparam int SCENE_GREEN  = 3;

  localparam logic [15:0] GREEN_565 = 16'h07E0;
  localparam logic [15:0] RED_565   = 16'hF800;
  // red block across the top left window corner
  localparam int BLOCK_X0 = 1;
  localparam int BLOCK_X1 = 7;
  localparam int BLOCK_Y0 = 0;
  localparam int BLOCK_Y1 = 5;

  logic             clk_pixel;
  logic             recent_reset;
  logic [PIX_W-1:0] pixel_i;
  logic             pixel_valid_i;
  logic             pixel_ready_o;
  logic [1:0]       mode_i;
  logic [3:0]       key_upper_i;
  logic             track_en_i;
  logic [23:0]      rgb_o;
  logic             hsync_o;
  logic             vsync_o;
  logic             de_o;

  int          errors;
  int          checks;
  logic [31:0] lfsr_state;
  // model of the held crosshair
  bit          cross_on;
  int          cross_x;
  int          cross_y;
  // raster position of the pixel now on the outputs
  bit          out_locked;
  int          out_h;
  int          out_v;

  `include "tb_model.svh"

  chroma_key_top #(
    .h_active(TB_H),
    .v_active(TB_V)
  ) dut0 (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .pixel_i      (pixel_i),
    .pixel_valid_i(pixel_valid_i),
    .pixel_ready_o(pixel_ready_o),
    .mode_i       (mode_i),
    .key_upper_i  (key_upper_i),
    .track_en_i   (track_en_i),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .de_o         (de_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  // ===========================================================================
  // stimulus helpers
  // ===========================================================================

  // one lfsr step per bit taken msb first
  task automatic random_pixel(output logic [15:0] pix);
    pix = '0;
    for (int i = 0; i < PIX_W; i++) begin
      pix = {pix[PIX_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic scene_pixel(input int kind, input int x, input int y,
                             output logic [15:0] pix, output logic valid);
    valid = 1'b1;
    case (kind)
      SCENE_RANDOM: random_pixel(pix);
      SCENE_FILL: begin
        // data keeps moving but is never offered
        random_pixel(pix);
        valid = 1'b0;
      end
      SCENE_BLOCK: begin
        pix = GREEN_565;
        if (x >= BLOCK_X0 && x < BLOCK_X1 && y >= BLOCK_Y0 && y < BLOCK_Y1) begin
          pix = RED_565;
        end
      end
      default: pix = GREEN_565;
    endcase
  endtask

  task automatic check_idle(input string name);
    checks++;
    if ({pixel_ready_o, de_o, hsync_o, vsync_o} !== 4'b0000) begin
      errors++;
      $display("[FAIL] %s: ready/de/hsync/vsync expected 0000, actual %b", name,
               {pixel_ready_o, de_o, hsync_o, vsync_o});
    end
    checks++;
    if (rgb_o !== 24'h000000) begin
      errors++;
      $display("[FAIL] %s: rgb expected 000000, actual %06h", name, rgb_o);
    end
  endtask

  // de_o, hsync_o and vsync_o against the output raster position
  task automatic compare_timing(input string name);
    logic [2:0] exp_tim;
    logic [2:0] act_tim;
    if (out_locked) begin
      exp_tim[2] = (out_h < TB_H) && (out_v < TB_V);
      exp_tim[1] = (out_h >= TB_H + H_FRONT) && (out_h < TB_H + H_FRONT + H_SYNC);
      exp_tim[0] = (out_v >= TB_V + V_FRONT) && (out_v < TB_V + V_FRONT + V_SYNC);
      act_tim = {de_o, hsync_o, vsync_o};
      checks++;
      if (act_tim !== exp_tim) begin
        errors++;
        $display("[FAIL] %s timing at (%0d,%0d): de/hsync/vsync expected %b, actual %b",
                 name, out_h, out_v, exp_tim, act_tim);
      end
      // step through the full raster including blanking
      out_h++;
      if (out_h == H_TOTAL) begin
        out_h = 0;
        out_v = (out_v + 1) % V_TOTAL;
      end
    end
  endtask

  // feed one frame of pixels while ready and compare de_o pixels in order
  task automatic run_frame(input string name, input int kind, input bit check);
    logic [23:0] exp_q[$];
    logic [23:0] expected;
    logic [15:0] pix;
    logic [15:0] used;
    logic        valid;
    bit          player;
    int          n_in;
    int          n_out;
    int          cycles;
    int          x;
    int          y;
    int          count;
    longint      sum_x;
    longint      sum_y;
    n_in = 0;
    n_out = 0;
    cycles = 0;
    count = 0;
    sum_x = 0;
    sum_y = 0;
    while (n_out < FRAME_PIXELS && cycles < 2 * FRAME_CYCLES) begin
      @(negedge clk_pixel);
      cycles++;
      // registered outputs are settled at the falling edge
      compare_timing(name);
      if (de_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: output pixel %0d came out before its input pixel", name, n_out);
        end else begin
          expected = exp_q.pop_front();
          if (check) begin
            checks++;
            if (rgb_o !== expected) begin
              errors++;
              $display("[FAIL] %s pixel (%0d,%0d): expected %06h, actual %06h", name,
                       n_out % TB_H, n_out / TB_H, expected, rgb_o);
            end
          end
        end
        n_out++;
      end
      // the next rising edge takes this input
      if (pixel_ready_o && n_in < FRAME_PIXELS) begin
        if (!out_locked) begin
          // the next falling edge sees the output raster OUT_LATENCY-1 cycles before (0,0)
          out_locked = 1'b1;
          out_h = H_TOTAL - OUT_LATENCY + 1;
          out_v = V_TOTAL - 1;
        end
        x = n_in % TB_H;
        y = n_in / TB_H;
        scene_pixel(kind, x, y, pix, valid);
        pixel_i = pix;
        pixel_valid_i = valid;
        used = valid ? pix : FILL_PIXEL;
        player = is_player(used, x, y, TB_H, TB_V, key_upper_i);
        exp_q.push_back(expect_pixel(mode_i, used, player, x, y, cross_on, cross_x, cross_y));
        if (player) begin
          sum_x += x;
          sum_y += y;
          count++;
        end
        n_in++;
      end else begin
        pixel_valid_i = 1'b0;
      end
    end
    if (n_out < FRAME_PIXELS) begin
      errors++;
      $display("%s: only %0d of %0d output pixels arrived within two frame times", name,
               n_out, FRAME_PIXELS);
    end
    // centroid of this frame shows from the next frame on
    if (track_en_i && count > 0) begin
      cross_on = 1'b1;
      cross_x = floor_mean(sum_x, count);
      cross_y = floor_mean(sum_y, count);
    end
  endtask

  // ===========================================================================
  // directed tests
  // ===========================================================================

  // reset held over three rising edges and then the first cycle out of it
  task automatic test_reset();
    recent_reset = 1'b1;
    repeat (2) begin
      @(negedge clk_pixel);
      check_idle("reset");
    end
    @(negedge clk_pixel);
    recent_reset = 1'b0;
    check_idle("after_reset");
  endtask

  task automatic test_camera();
    mode_i = DISP_CAMERA;
    track_en_i = 1'b0;
    cross_on = 1'b0;
    run_frame("camera", SCENE_RANDOM, 1'b1);
    run_frame("camera_fill", SCENE_FILL, 1'b1);
  endtask

  task automatic test_luma();
    mode_i = DISP_LUMA;
    run_frame("luma", SCENE_RANDOM, 1'b1);
  endtask

  task automatic test_mask_overlay();
    mode_i = DISP_MASK;
    run_frame("mask", SCENE_BLOCK, 1'b1);
    mode_i = DISP_OVERLAY;
    run_frame("overlay", SCENE_BLOCK, 1'b1);
  endtask

  task automatic test_tracking();
    mode_i = DISP_OVERLAY;
    track_en_i = 1'b1;
    run_frame("track_block", SCENE_BLOCK, 1'b1);
    // crosshair may still be settling here
    run_frame("track_settle", SCENE_BLOCK, 1'b0);
    run_frame("track_cross", SCENE_GREEN, 1'b1);
    // empty frame keeps the held centre
    run_frame("track_hold", SCENE_GREEN, 1'b1);
    track_en_i = 1'b0;
    cross_on = 1'b0;
  endtask

  initial begin
    recent_reset = 1'b1;
    pixel_i = '0;
    pixel_valid_i = 1'b0;
    mode_i = DISP_CAMERA;
    key_upper_i = 4'd4;
    track_en_i = 1'b0;
    errors = 0;
    checks = 0;
    lfsr_state = 32'h3b77e67b;
    cross_on = 1'b0;
    cross_x = 0;
    cross_y = 0;
    out_locked = 1'b0;
    out_h = 0;
    out_v = 0;

    test_reset();
    test_camera();
    test_luma();
    test_mask_overlay();
    test_tracking();

    $display("tb_chroma_key: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: chroma_key_top.sv
`timescale 1ns/10ps

module chroma_key_top import tracker_pkg::*; #(
  parameter int h_active = H_ACTIVE,
  parameter int v_active = V_ACTIVE
) (
  input  logic             clk_pixel,
  input  logic             recent_reset,
  input  logic [PIX_W-1:0] pixel_i,
  input  logic             pixel_valid_i,
  output logic             pixel_ready_o,
  input  logic [1:0]       mode_i,
  input  logic [3:0]       key_upper_i,
  input  logic             track_en_i,
  output logic [23:0]      rgb_o,
  output logic             hsync_o,
  output logic             vsync_o,
  output logic             de_o
);

  logic [HCOUNT_W-1:0]     hcount;
  logic [VCOUNT_W-1:0]     vcount;
  logic                    hsync, vsync, active, frame_end;
  logic [PIX_W-1:0]        pixel_in;
  logic                    in_window;
  // in the raster delay lines bit k holds the value from k+1 cycles ago
  logic [OUT_LATENCY-1:0]  act_sr, hs_sr, vs_sr;
  logic [CONV_LATENCY-1:0] fe_sr;
  logic [HCOUNT_W-1:0]     hc_sr [CONV_LATENCY];
  logic [VCOUNT_W-1:0]     vc_sr [CONV_LATENCY];
  logic [23:0]             cls_rgb;
  logic [CHAN_W-1:0]       cls_luma;
  logic                    cls_player;
  logic [HCOUNT_W-1:0]     cx, cross_x;
  logic [VCOUNT_W-1:0]     cy, cross_y;
  logic                    centroid_valid;
  logic                    have_centroid;

  raster_timer #(
    .h_active(h_active),
    .v_active(v_active)
  ) timer0 (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .hcount_o    (hcount),
    .vcount_o    (vcount),
    .hsync_o     (hsync),
    .vsync_o     (vsync),
    .active_o    (active),
    .frame_end_o (frame_end)
  );

  // ==========================================================================
  // pixel intake and game window
  // ==========================================================================
  // the raster never waits and a missing pixel becomes the fill colour
  assign pixel_ready_o = active;
  assign pixel_in      = pixel_valid_i ? pixel_i : FILL_PIXEL;

  assign in_window = (hcount >= h_active / WINDOW_DIV) &&
                     (hcount < h_active - h_active / WINDOW_DIV) &&
                     (vcount >= v_active / WINDOW_DIV) &&
                     (vcount < v_active - v_active / WINDOW_DIV);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      act_sr <= '0;
      hs_sr  <= '0;
      vs_sr  <= '0;
      fe_sr  <= '0;
    end else begin
      act_sr <= {act_sr[OUT_LATENCY-2:0], active};
      hs_sr  <= {hs_sr[OUT_LATENCY-2:0], hsync};
      vs_sr  <= {vs_sr[OUT_LATENCY-2:0], vsync};
      fe_sr  <= {fe_sr[CONV_LATENCY-2:0], frame_end};
    end
  end

  // coordinate delay lines for the execute and result stages
  always_ff @(posedge clk_pixel) begin
    hc_sr[0] <= hcount;
    vc_sr[0] <= vcount;
    for (int i = 1; i < CONV_LATENCY; i++) begin
      hc_sr[i] <= hc_sr[i-1];
      vc_sr[i] <= vc_sr[i-1];
    end
  end

  // ==========================================================================
  // decode, execute, result
  // ==========================================================================
  pixel_classifier classify0 (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .pixel_i     (pixel_in),
    .in_window_i (in_window),
    .key_upper_i (key_upper_i),
    .rgb_o       (cls_rgb),
    .luma_o      (cls_luma),
    .player_o    (cls_player)
  );

  centroid_tracker track0 (
    .clk_pixel       (clk_pixel),
    .recent_reset    (recent_reset),
    .player_i        (cls_player && act_sr[CONV_LATENCY-1]),
    .hcount_i        (hc_sr[CONV_LATENCY-1]),
    .vcount_i        (vc_sr[CONV_LATENCY-1]),
    .frame_end_i     (fe_sr[CONV_LATENCY-1]),
    .track_en_i      (track_en_i),
    .cx_o            (cx),
    .cy_o            (cy),
    .centroid_valid_o(centroid_valid)
  );

  // crosshair stays hidden until tracking has produced a centroid
  always_ff @(posedge clk_pixel) begin
    if (recent_reset || !track_en_i) begin
      have_centroid <= 1'b0;
    end else if (centroid_valid) begin
      have_centroid <= 1'b1;
    end
  end

  // all ones lies outside any raster these counters cover
  assign cross_x = have_centroid ? cx : '1;
  assign cross_y = have_centroid ? cy : '1;

  overlay_mux mux0 (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .mode_i      (mode_i),
    .rgb_i       (cls_rgb),
    .luma_i      (cls_luma),
    .player_i    (cls_player),
    .de_i        (act_sr[CONV_LATENCY-1]),
    .hcount_i    (hc_sr[CONV_LATENCY-1]),
    .vcount_i    (vc_sr[CONV_LATENCY-1]),
    .cx_i        (cross_x),
    .cy_i        (cross_y),
    .rgb_o       (rgb_o)
  );

  // video timing lines up with the registered pixel
  assign de_o    = act_sr[OUT_LATENCY-1];
  assign hsync_o = hs_sr[OUT_LATENCY-1];
  assign vsync_o = vs_sr[OUT_LATENCY-1];

endmodule

// File: overlay_mux.sv
`timescale 1ns/10ps

module overlay_mux import tracker_pkg::*; (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  input  logic [1:0]          mode_i,
  input  logic [23:0]         rgb_i,
  input  logic [CHAN_W-1:0]   luma_i,
  input  logic                player_i,
  input  logic                de_i,
  input  logic [HCOUNT_W-1:0] hcount_i,
  input  logic [VCOUNT_W-1:0] vcount_i,
  input  logic [HCOUNT_W-1:0] cx_i,
  input  logic [VCOUNT_W-1:0] cy_i,
  output logic [23:0]         rgb_o
);

  logic [23:0] bg;
  logic [23:0] pix;

  always_comb begin
    // background per display mode
    unique case (mode_i)
      DISP_CAMERA:  bg = rgb_i;
      DISP_LUMA:    bg = {3{luma_i}};
      DISP_MASK:    bg = player_i ? 24'hFFFFFF : 24'h000000;
      DISP_OVERLAY: bg = player_i ? MASK_COLOR : rgb_i;
    endcase
    // crosshair on top, full row and full column through the centroid
    pix = bg;
    if ((hcount_i == cx_i) || (vcount_i == cy_i)) begin
      pix = CROSS_COLOR;
    end
  end

  // output register, black outside active draw
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      rgb_o <= '0;
    end else begin
      rgb_o <= de_i ? pix : 24'h000000;
    end
  end

endmodule

// File: centroid_tracker.sv
`timescale 1ns/10ps

module centroid_tracker import tracker_pkg::*; (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  input  logic                player_i,
  input  logic [HCOUNT_W-1:0] hcount_i,
  input  logic [VCOUNT_W-1:0] vcount_i,
  input  logic                frame_end_i,
  input  logic                track_en_i,
  output logic [HCOUNT_W-1:0] cx_o,
  output logic [VCOUNT_W-1:0] cy_o,
  output logic                centroid_valid_o
);

  logic [SUM_W-1:0]    sum_x, sum_y;
  logic [SUM_W-1:0]    sum_x_nxt, sum_y_nxt;
  logic [CNT_W-1:0]    cnt, cnt_nxt;
  logic                div_start;
  logic [HCOUNT_W-1:0] qx, qy;
  logic                done_x, done_y;
  logic                both_done;

  // totals including the current pixel so the last active pixel still counts
  always_comb begin
    sum_x_nxt = sum_x;
    sum_y_nxt = sum_y;
    cnt_nxt   = cnt;
    if (player_i) begin
      sum_x_nxt = sum_x + SUM_W'(hcount_i);
      sum_y_nxt = sum_y + SUM_W'(vcount_i);
      cnt_nxt   = cnt + 1'b1;
    end
  end

  // empty frames or tracking off leave the held centroid alone
  assign div_start = frame_end_i && track_en_i && (cnt_nxt != '0);

  // ==========================================================================
  // per-frame accumulation
  // ==========================================================================
  always_ff @(posedge clk_pixel) begin
    if (recent_reset || frame_end_i) begin
      sum_x <= '0;
      sum_y <= '0;
      cnt   <= '0;
    end else begin
      sum_x <= sum_x_nxt;
      sum_y <= sum_y_nxt;
      cnt   <= cnt_nxt;
    end
  end

  // both dividers capture the totals on the start pulse
  centroid_divider div_x (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .start_i     (div_start),
    .dividend_i  (sum_x_nxt),
    .divisor_i   (cnt_nxt),
    .quotient_o  (qx),
    .done_o      (done_x)
  );

  centroid_divider div_y (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .start_i     (div_start),
    .dividend_i  (sum_y_nxt),
    .divisor_i   (cnt_nxt),
    .quotient_o  (qy),
    .done_o      (done_y)
  );

  // ==========================================================================
  // held centroid
  // ==========================================================================
  // both divides start together and run for the same number of cycles
  assign both_done = done_x && done_y;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      cx_o             <= '0;
      cy_o             <= '0;
      centroid_valid_o <= 1'b0;
    end else begin
      centroid_valid_o <= 1'b0;
      if (both_done) begin
        // the y mean always fits the line counter
        cx_o             <= qx;
        cy_o             <= qy[VCOUNT_W-1:0];
        centroid_valid_o <= 1'b1;
      end
    end
  end

endmodule

// File: centroid_divider.sv
`timescale 1ns/10ps

module centroid_divider import tracker_pkg::*; (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  input  logic                start_i,
  input  logic [SUM_W-1:0]    dividend_i,
  input  logic [CNT_W-1:0]    divisor_i,
  output logic [HCOUNT_W-1:0] quotient_o,
  output logic                done_o
);

  // dividend bits shift out of the top while quotient bits shift in below
  logic [SUM_W-1:0]     quo;
  logic [CNT_W-1:0]     rem;
  logic [CNT_W-1:0]     dvs;
  logic [CNT_W:0]       rem_sh;
  // one extra bit carries the borrow of the trial subtract
  logic [CNT_W+1:0]     diff;
  logic [DIV_CNT_W-1:0] bits_left;
  logic                 busy;

  assign rem_sh = {rem, quo[SUM_W-1]};
  assign diff   = {1'b0, rem_sh} - {2'b00, dvs};

  // control, one iteration per cycle for SUM_W cycles
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      busy      <= 1'b0;
      done_o    <= 1'b0;
      bits_left <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busy      <= 1'b1;
        bits_left <= DIV_CNT_W'(SUM_W - 1);
      end else if (busy) begin
        bits_left <= bits_left - 1'b1;
        if (bits_left == '0) begin
          busy   <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk_pixel) begin
    if (start_i) begin
      quo <= dividend_i;
      rem <= '0;
      dvs <= divisor_i;
    end else if (busy) begin
      if (!diff[CNT_W+1]) begin
        // trial subtract fits, keep it
        rem <= diff[CNT_W-1:0];
        quo <= {quo[SUM_W-2:0], 1'b1};
      end else begin
        // restore the shifted remainder
        rem <= rem_sh[CNT_W-1:0];
        quo <= {quo[SUM_W-2:0], 1'b0};
      end
    end
  end

  // a mean coordinate never exceeds the counter width
  assign quotient_o = quo[HCOUNT_W-1:0];

endmodule

// File: pixel_classifier.sv
`timescale 1ns/10ps

module pixel_classifier import tracker_pkg::*; (
  input  logic              clk_pixel,
  input  logic              recent_reset,
  input  logic [PIX_W-1:0]  pixel_i,
  input  logic              in_window_i,
  input  logic [3:0]        key_upper_i,
  output logic [23:0]       rgb_o,
  output logic [CHAN_W-1:0] luma_o,
  output logic              player_o
);

  // stage 1, expanded RGB888
  logic [CHAN_W-1:0] r1, g1, b1;
  // stage 2, partial products
  logic [15:0] yr2, yg2, yb2;
  logic [15:0] crr2, crg2, crb2;
  logic [15:0] cbr2, cbg2, cbb2;
  // stage 3, sums kept mod 2^16, the chroma sums are two's complement
  logic [15:0] y3, cr3, cb3;
  // stage 4, scaled and offset channels
  logic [CHAN_W-1:0] y4, cr4, cb4;
  // camera pixel riding along with the maths, latencies 2 to 4
  logic [23:0] rgb_d [CONV_LATENCY-2];
  // window flag, latencies 1 to 4
  logic [CONV_LATENCY-2:0] win_sr;
  logic [CHAN_W-1:0] key_thresh;
  logic backdrop;

  // ==========================================================================
  // colour conversion datapath
  // ==========================================================================
  always_ff @(posedge clk_pixel) begin
    // 5:6:5 fields left aligned, low bits zero
    r1 <= {pixel_i[15:11], 3'b000};
    g1 <= {pixel_i[10:5], 2'b00};
    b1 <= {pixel_i[4:0], 3'b000};

    yr2  <= 16'd66 * r1;
    yg2  <= 16'd129 * g1;
    yb2  <= 16'd25 * b1;
    crr2 <= 16'd112 * r1;
    crg2 <= 16'd94 * g1;
    crb2 <= 16'd18 * b1;
    cbr2 <= 16'd38 * r1;
    cbg2 <= 16'd74 * g1;
    cbb2 <= 16'd112 * b1;

    y3  <= yr2 + yg2 + yb2;
    cr3 <= crr2 - crg2 - crb2;
    cb3 <= cbb2 - cbr2 - cbg2;

    // upper byte is the floor of sum/256, then offset and wrap to 8 bits
    y4  <= y3[15:8] + 8'd16;
    cr4 <= cr3[15:8] + 8'd128;
    cb4 <= cb3[15:8] + 8'd128;
    luma_o <= y4;

    rgb_d[0] <= {r1, g1, b1};
    for (int i = 1; i < CONV_LATENCY - 2; i++) begin
      rgb_d[i] <= rgb_d[i-1];
    end
    rgb_o <= rgb_d[CONV_LATENCY-3];
  end

  // ==========================================================================
  // backdrop key
  // ==========================================================================
  // threshold in steps of 16, both chroma channels must sit under it
  assign key_thresh = {key_upper_i, 4'b0000};
  assign backdrop = (cr4 <= key_thresh) && (cb4 <= key_thresh);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      win_sr   <= '0;
      player_o <= 1'b0;
    end else begin
      win_sr   <= {win_sr[CONV_LATENCY-3:0], in_window_i};
      player_o <= !backdrop && win_sr[CONV_LATENCY-2];
    end
  end

endmodule

// File: raster_timer.sv
`timescale 1ns/10ps

module raster_timer import tracker_pkg::*; #(
  parameter int h_active = H_ACTIVE,
  parameter int h_front  = H_FRONT,
  parameter int h_sync   = H_SYNC,
  parameter int h_back   = H_BACK,
  parameter int v_active = V_ACTIVE,
  parameter int v_front  = V_FRONT,
  parameter int v_sync   = V_SYNC,
  parameter int v_back   = V_BACK
) (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  output logic [HCOUNT_W-1:0] hcount_o,
  output logic [VCOUNT_W-1:0] vcount_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                active_o,
  output logic                frame_end_o
);

  logic h_last;
  logic v_last;

  // last pixel of a line and last line of the raster, blanking included
  assign h_last = (hcount_o == HCOUNT_W'(h_active + h_front + h_sync + h_back - 1));
  assign v_last = (vcount_o == VCOUNT_W'(v_active + v_front + v_sync + v_back - 1));

  // reset parks the counters on the very last raster position
  // so the first cycle out of reset is blanking and the next one is (0,0)
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hcount_o <= HCOUNT_W'(h_active + h_front + h_sync + h_back - 1);
      vcount_o <= VCOUNT_W'(v_active + v_front + v_sync + v_back - 1);
    end else if (h_last) begin
      hcount_o <= '0;
      vcount_o <= v_last ? '0 : vcount_o + 1'b1;
    end else begin
      hcount_o <= hcount_o + 1'b1;
    end
  end

  // positive sync pulses, placed after the front porch
  assign hsync_o = (hcount_o >= h_active + h_front) && (hcount_o < h_active + h_front + h_sync);
  assign vsync_o = (vcount_o >= v_active + v_front) && (vcount_o < v_active + v_front + v_sync);

  assign active_o = (hcount_o < h_active) && (vcount_o < v_active);

  // one cycle on the bottom right active pixel
  assign frame_end_o = (hcount_o == HCOUNT_W'(h_active - 1)) &&
                       (vcount_o == VCOUNT_W'(v_active - 1));

endmodule

// File: tracker_pkg.sv
package tracker_pkg;

  // ==========================================================================
  // raster defaults, 720p at 60 Hz
  // ==========================================================================
  localparam int H_ACTIVE = 1280;
  localparam int V_ACTIVE = 720;
  localparam int H_FRONT  = 110;
  localparam int H_SYNC   = 40;
  localparam int H_BACK   = 220;
  localparam int V_FRONT  = 5;
  localparam int V_SYNC   = 5;
  localparam int V_BACK   = 20;

  // counter widths, sized for the full 1650 x 750 raster
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // ==========================================================================
  // pixel formats and pipeline depth
  // ==========================================================================
  localparam int PIX_W  = 16;
  localparam int CHAN_W = 8;

  // substituted when the frame buffer has nothing to offer
  localparam logic [PIX_W-1:0] FILL_PIXEL = 16'h2277;

  // acceptance to key bit, then one more register in the output mux
  localparam int CONV_LATENCY = 5;
  localparam int OUT_LATENCY  = 6;

  // ==========================================================================
  // tracking and overlay
  // ==========================================================================
  // one tenth of each edge is outside the game window
  localparam int WINDOW_DIV = 10;

  localparam logic [23:0] CROSS_COLOR = 24'hFF0000;
  localparam logic [23:0] MASK_COLOR  = 24'hFF00FF;

  localparam logic [1:0] DISP_CAMERA  = 2'd0;
  localparam logic [1:0] DISP_LUMA    = 2'd1;
  localparam logic [1:0] DISP_MASK    = 2'd2;
  localparam logic [1:0] DISP_OVERLAY = 2'd3;

  // full-frame coordinate sum and pixel count
  localparam int SUM_W     = 31;
  localparam int CNT_W     = 21;
  // divider iteration counter
  localparam int DIV_CNT_W = $clog2(SUM_W);

endpackage
